/* rtl/la_isa_pkg.sv */
package la_isa_pkg;

    localparam int xlen       = 32;
    localparam int reg_addr_w = 5;
    localparam int strb_w     = xlen / 8;   // one enable per byte lane
    localparam int ecode_w    = 6;

    // loongarch ecode for address alignment fault
    localparam logic [ecode_w-1:0] ecode_ale = 6'h09;

    typedef enum logic [3:0] {
        op_alu   = 4'd0,    // plain alu writeback, no memory access
        op_ld_b  = 4'd1,
        op_ld_h  = 4'd2,
        op_ld_w  = 4'd3,
        op_ld_bu = 4'd4,
        op_ld_hu = 4'd5,
        op_st_b  = 4'd6,
        op_st_h  = 4'd7,
        op_st_w  = 4'd8
    } mem_op_e;

    typedef enum logic [1:0] {
        sz_byte = 2'd0,
        sz_half = 2'd1,
        sz_word = 2'd2
    } size_e;

    // access width of a memory op
    // op_alu reports word, callers mask it out
    function automatic size_e op_size(mem_op_e op);
        case (op)
            op_ld_b, op_ld_bu, op_st_b: begin
                op_size = sz_byte;
            end
            op_ld_h, op_ld_hu, op_st_h: begin
                op_size = sz_half;
            end
            default: begin
                op_size = sz_word;
            end
        endcase
    endfunction

endpackage

/* rtl/lsu_bus_pkg.sv */
package lsu_bus_pkg;

    // request entering the memory stage, one per cycle
    typedef struct packed {
        logic                                 valid;
        la_isa_pkg::mem_op_e                  op;
        logic [la_isa_pkg::reg_addr_w-1:0]    rd;
        logic [la_isa_pkg::xlen-1:0]          alu_result;  // effective address for ld/st
        logic [la_isa_pkg::xlen-1:0]          store_data;
    } mem_req_t;

    // data sram port, synchronous read with one cycle latency
    typedef struct packed {
        logic                                 en;
        logic [la_isa_pkg::strb_w-1:0]        we;          // byte enables, zero on reads
        logic [la_isa_pkg::xlen-1:0]          addr;
        logic [la_isa_pkg::xlen-1:0]          wdata;
    } sram_req_t;

    // register file write from writeback
    typedef struct packed {
        logic                                 we;
        logic [la_isa_pkg::reg_addr_w-1:0]    wnum;
        logic [la_isa_pkg::xlen-1:0]          wdata;
    } rf_wr_t;

    // exception report toward the csr side
    typedef struct packed {
        logic                                 valid;
        logic [la_isa_pkg::ecode_w-1:0]       ecode;
        logic [la_isa_pkg::xlen-1:0]          badv;        // faulting address
    } lsu_ex_t;

endpackage

/* rtl/lsu_align_check.sv */
`timescale 1ns/1ps

module lsu_align_check (
    input  lsu_bus_pkg::mem_req_t req,
    output logic                  ale
);

    import la_isa_pkg::*;

    size_e       acc_size;
    logic [1:0]  offset;
    logic        misaligned;
    logic        is_mem;

    assign acc_size = op_size(req.op);
    assign offset   = req.alu_result[1:0];
    assign is_mem   = req.op != op_alu;

    // low address bits must be zero for the access width
    always_comb begin
        case (acc_size)
            sz_byte: begin
                misaligned = 1'b0;          // bytes never fault
            end
            sz_half: begin
                misaligned = offset[0];
            end
            sz_word: begin
                misaligned = |offset;
            end
            default: begin
                misaligned = 1'b0;
            end
        endcase
    end

    // only real memory accesses can fault
    assign ale = req.valid && is_mem && misaligned;

endmodule

/* rtl/lsu_store_format.sv */
`timescale 1ns/1ps

module lsu_store_format (
    input  lsu_bus_pkg::mem_req_t  req,
    output lsu_bus_pkg::sram_req_t fmt_sram
);

    import la_isa_pkg::*;

    size_e              acc_size;
    logic [1:0]         offset;
    logic               is_mem;
    logic               is_store;
    logic [strb_w-1:0]  lane_mask;
    logic [xlen-1:0]    lane_data;

    assign acc_size = op_size(req.op);
    assign offset   = req.alu_result[1:0];
    assign is_mem   = req.op != op_alu;
    assign is_store = req.op inside {op_st_b, op_st_h, op_st_w};

    // enable pattern and replicated data per access width
    always_comb begin
        case (acc_size)
            sz_byte: begin
                lane_mask = 4'b0001 << offset;
                lane_data = {4{req.store_data[7:0]}};
            end
            sz_half: begin
                // halfword address, bit 0 ignored here
                lane_mask = 4'b0011 << {offset[1], 1'b0};
                lane_data = {2{req.store_data[15:0]}};
            end
            sz_word: begin
                lane_mask = 4'b1111;
                lane_data = req.store_data;
            end
            default: begin
                lane_mask = '0;
                lane_data = req.store_data;
            end
        endcase
    end

    always_comb begin
        fmt_sram.en    = req.valid && is_mem;
        fmt_sram.we    = (req.valid && is_store) ? lane_mask : '0;  // loads read only
        fmt_sram.addr  = req.alu_result;
        fmt_sram.wdata = lane_data;
    end

endmodule

/* rtl/lsu_commit.sv */
`timescale 1ns/1ps

module lsu_commit (
    input  logic                          clk,
    input  logic                          arst_n,
    input  lsu_bus_pkg::mem_req_t         req,
    input  logic                          ale,
    input  lsu_bus_pkg::sram_req_t        fmt_sram,
    input  logic [la_isa_pkg::xlen-1:0]   data_sram_rdata,
    output lsu_bus_pkg::sram_req_t        data_sram,
    output lsu_bus_pkg::rf_wr_t           rf_wr,
    output lsu_bus_pkg::lsu_ex_t          ex
);

    import la_isa_pkg::*;

    // writeback stage state
    logic                   wb_valid;
    logic                   wb_ale;
    mem_op_e                wb_op;
    logic [reg_addr_w-1:0]  wb_rd;
    logic [xlen-1:0]        wb_alu_result;

    logic                   wb_is_load;
    logic                   wb_is_alu;
    logic [1:0]             wb_offset;
    logic [7:0]             ld_byte;
    logic [15:0]            ld_half;
    logic [xlen-1:0]        ld_value;

    // memory stage, a faulting request must not touch the sram
    always_comb begin
        data_sram    = fmt_sram;
        data_sram.we = ale ? '0 : fmt_sram.we;
    end

    always_ff @(posedge clk or negedge arst_n) begin
        if (!arst_n) begin
            wb_valid <= 1'b0;
            wb_ale   <= 1'b0;
        end else begin
            wb_valid <= req.valid;
            wb_ale   <= ale;        // already qualified by valid
        end
    end

    always_ff @(posedge clk) begin
        if (req.valid) begin
            wb_op         <= req.op;
            wb_rd         <= req.rd;
            wb_alu_result <= req.alu_result;
        end
    end

    assign wb_is_load = wb_op inside {op_ld_b, op_ld_h, op_ld_w, op_ld_bu, op_ld_hu};
    assign wb_is_alu  = wb_op == op_alu;
    assign wb_offset  = wb_alu_result[1:0];

    // sram word arrives this cycle, pick the addressed lane
    assign ld_byte = data_sram_rdata[{wb_offset, 3'b000} +: 8];
    assign ld_half = data_sram_rdata[{wb_offset[1], 4'b0000} +: 16];

    always_comb begin
        case (wb_op)
            op_ld_b: begin
                ld_value = {{24{ld_byte[7]}}, ld_byte};
            end
            op_ld_bu: begin
                ld_value = {24'b0, ld_byte};
            end
            op_ld_h: begin
                ld_value = {{16{ld_half[15]}}, ld_half};
            end
            op_ld_hu: begin
                ld_value = {16'b0, ld_half};
            end
            op_ld_w: begin
                ld_value = data_sram_rdata;
            end
            default: begin
                ld_value = '0;
            end
        endcase
    end

    // stores never write the register file
    always_comb begin
        rf_wr.we    = wb_valid && !wb_ale && (wb_is_alu || wb_is_load);
        rf_wr.wnum  = wb_rd;
        rf_wr.wdata = wb_is_load ? ld_value : wb_alu_result;
    end

    always_comb begin
        ex.valid = wb_ale;
        ex.ecode = ecode_ale;
        ex.badv  = wb_alu_result;   // faulting effective address
    end

endmodule

/* rtl/lsu_top.sv */
`timescale 1ns/1ps

module lsu_top (
    input  logic                          clk,
    input  logic                          arst_n,
    input  lsu_bus_pkg::mem_req_t         req,
    output lsu_bus_pkg::sram_req_t        data_sram,
    input  logic [la_isa_pkg::xlen-1:0]   data_sram_rdata,
    output lsu_bus_pkg::rf_wr_t           rf_wr,
    output lsu_bus_pkg::lsu_ex_t          ex
);

    import lsu_bus_pkg::*;

    logic       ale;
    sram_req_t  fmt_sram;   // ungated sram request

    // alignment check and formatting work on the same request
    lsu_align_check u_align (
        .req (req),
        .ale (ale)
    );

    lsu_store_format u_store (
        .req      (req),
        .fmt_sram (fmt_sram)
    );

    lsu_commit u_commit (
        .clk             (clk),
        .arst_n          (arst_n),
        .req             (req),
        .ale             (ale),
        .fmt_sram        (fmt_sram),
        .data_sram_rdata (data_sram_rdata),
        .data_sram       (data_sram),
        .rf_wr           (rf_wr),
        .ex              (ex)
    );

endmodule

/* testbench/lsu_props.sv */
`timescale 1ns/1ps

module lsu_props (
    input  logic                   clk,
    input  logic                   arst_n,
    input  lsu_bus_pkg::mem_req_t  req,
    input  logic                   ale,
    input  lsu_bus_pkg::sram_req_t data_sram,
    input  lsu_bus_pkg::rf_wr_t    rf_wr,
    input  lsu_bus_pkg::lsu_ex_t   ex
);

    import la_isa_pkg::*;

    logic req_is_store;

    assign req_is_store = req.valid && (req.op inside {op_st_b, op_st_h, op_st_w});

    // a faulting access never writes the sram
    ale_blocks_write: assert property (
        @(posedge clk) disable iff (!arst_n)
        ale |-> (data_sram.we == '0)
    ) else $error("sram byte enables set while ale is high");

    ex_rf_exclusive: assert property (
        @(posedge clk) disable iff (!arst_n)
        !(ex.valid && rf_wr.we)
    ) else $error("exception and register write in the same cycle");

    // store in memory stage, no register write next cycle
    no_rf_after_store: assert property (
        @(posedge clk) disable iff (!arst_n)
        req_is_store |=> !rf_wr.we
    ) else $error("register write in the cycle after a store");

endmodule

bind lsu_top lsu_props u_props (
    .clk       (clk),
    .arst_n    (arst_n),
    .req       (req),
    .ale       (ale),
    .data_sram (data_sram),
    .rf_wr     (rf_wr),
    .ex        (ex)
);

/* testbench/tb_lsu_top.sv */
`timescale 1ns/1ps

module tb_lsu_top;

    import la_isa_pkg::*;
    import lsu_bus_pkg::*;

    localparam int n_req          = 2000;
    localparam int timeout_cycles = n_req + 50;
    localparam logic [xlen-1:0] mem_base = 32'h0000_8000;  // 64-word window, low byte clear

    logic            clk = 1'b0;
    logic            arst_n;
    mem_req_t        req;
    sram_req_t       data_sram;
    logic [xlen-1:0] data_sram_rdata;
    rf_wr_t          rf_wr;
    lsu_ex_t         ex;

    logic [xlen-1:0] sram_mem [0:63];   // written only by the dut port
    logic [xlen-1:0] shadow   [0:63];   // reference copy

    integer          seed;
    int              cycle_cnt = 0;
    int              mem_errs;
    int              wb_errs;
    int              ex_errs;
    int              reset_errs;
    logic            last_store;        // previous request was a valid store
    logic [5:0]      last_word;

    mem_req_t        cur_req;
    sram_req_t       cur_sram;
    rf_wr_t          cur_rf;
    rf_wr_t          prev_rf;
    lsu_ex_t         cur_ex;
    lsu_ex_t         prev_ex;

    lsu_top u_lsu_top (
        .clk             (clk),
        .arst_n          (arst_n),
        .req             (req),
        .data_sram       (data_sram),
        .data_sram_rdata (data_sram_rdata),
        .rf_wr           (rf_wr),
        .ex              (ex)
    );

    always #2 clk = ~clk;

    // synchronous sram, read data one cycle after en
    always @(posedge clk) begin
        if (data_sram.en) begin
            data_sram_rdata <= sram_mem[data_sram.addr[7:2]];
            for (int b = 0; b < 4; b++) begin
                if (data_sram.we[b]) begin
                    sram_mem[data_sram.addr[7:2]][8*b +: 8] <= data_sram.wdata[8*b +: 8];
                end
            end
        end
    end

    always @(posedge clk) begin
        cycle_cnt <= cycle_cnt + 1;
        if (cycle_cnt >= timeout_cycles) begin
            $display("timeout: run did not finish within %0d cycles", timeout_cycles);
            print_counts();
            $display("Test failed");
            $finish;
        end
    end

    function automatic logic [xlen-1:0] fill_word(int idx);
        return 32'h8bad_f00d ^ (idx * 32'h0100_0193);
    endfunction

    // bytes touched by an op, 0 for plain alu
    function automatic int access_bytes(mem_op_e op);
        case (op)
            op_ld_b, op_ld_bu, op_st_b: return 1;
            op_ld_h, op_ld_hu, op_st_h: return 2;
            op_ld_w, op_st_w:           return 4;
            default:                    return 0;
        endcase
    endfunction

    function automatic logic is_load_op(mem_op_e op);
        return op == op_ld_b || op == op_ld_h || op == op_ld_w ||
               op == op_ld_bu || op == op_ld_hu;
    endfunction

    function automatic logic is_store_op(mem_op_e op);
        return op == op_st_b || op == op_st_h || op == op_st_w;
    endfunction

    task automatic show_mismatch(string sig, logic [31:0] exp_val, logic [31:0] got_val);
        $display("MISMATCH at %0t: %s expected %h, got %h", $time, sig, exp_val, got_val);
    endtask

    task automatic build_request(output mem_req_t r);
        logic [31:0] rnd;
        int          op_idx;
        int          nb;
        logic [5:0]  word_idx;
        logic [1:0]  off;
        rnd = $random(seed);
        r = '0;
        r.valid = (rnd[3:0] != 4'd0);           // roughly one idle slot in 16
        op_idx = int'(rnd[11:4]) % 9;
        word_idx = rnd[17:12];
        if (last_store && rnd[20:18] < 3'd3) begin
            op_idx = 1 + int'(rnd[23:21]) % 5;  // load right behind the store
            word_idx = last_word;
        end
        r.op = mem_op_e'(op_idx[3:0]);
        nb = access_bytes(r.op);
        if (rnd[24]) begin
            off = rnd[26:25];                   // any offset, often misaligned
        end else if (nb == 4) begin
            off = 2'b00;
        end else if (nb == 2) begin
            off = {rnd[25], 1'b0};
        end else begin
            off = rnd[26:25];
        end
        r.rd = rnd[31:27];
        r.alu_result = mem_base | {24'h0, word_idx, off};
        if (nb == 0) begin
            r.alu_result = $random(seed);
        end
        r.store_data = $random(seed);
        last_store = r.valid && is_store_op(r.op);
        last_word = word_idx;
    endtask

    // expected sram port now, rf write and exception one cycle later
    task automatic predict(input mem_req_t r, output sram_req_t s,
                           output rf_wr_t w, output lsu_ex_t e);
        int          nb;
        int          off;
        logic        misal;
        logic        fault;
        logic [31:0] word;
        logic [7:0]  byte_lane;
        logic [15:0] half_lane;
        logic [31:0] value;
        nb = access_bytes(r.op);
        off = int'(r.alu_result[1:0]);
        misal = (nb != 0) && ((off % nb) != 0);
        fault = r.valid && misal;
        s = '0;
        s.en = r.valid && (nb != 0);
        s.addr = r.alu_result;
        if (nb != 0) begin
            for (int k = 0; k < 4; k++) begin
                s.wdata[8*k +: 8] = r.store_data[8*(k % nb) +: 8];
            end
        end
        if (r.valid && is_store_op(r.op) && !misal) begin
            s.we = 4'(((1 << nb) - 1) << off);
        end
        word = shadow[r.alu_result[7:2]];
        byte_lane = word[8*off +: 8];
        half_lane = word[16*(off/2) +: 16];
        case (r.op)
            op_ld_b:  value = {{24{byte_lane[7]}}, byte_lane};
            op_ld_bu: value = {24'h0, byte_lane};
            op_ld_h:  value = {{16{half_lane[15]}}, half_lane};
            op_ld_hu: value = {16'h0, half_lane};
            op_ld_w:  value = word;
            default:  value = r.alu_result;
        endcase
        w.we = r.valid && !fault && (nb == 0 || is_load_op(r.op));
        w.wnum = r.rd;
        w.wdata = value;
        e.valid = fault;
        e.ecode = ecode_ale;
        e.badv = r.alu_result;
    endtask

    task automatic update_shadow(input sram_req_t s);
        for (int b = 0; b < 4; b++) begin
            if (s.we[b]) begin
                shadow[s.addr[7:2]][8*b +: 8] = s.wdata[8*b +: 8];
            end
        end
    endtask

    task automatic check_mem_stage(input sram_req_t s);
        if (data_sram.en !== s.en) begin
            show_mismatch("data_sram.en", 32'(s.en), 32'(data_sram.en));
            mem_errs++;
        end
        if (data_sram.we !== s.we) begin
            show_mismatch("data_sram.we", 32'(s.we), 32'(data_sram.we));
            mem_errs++;
        end
        if (s.en && data_sram.addr !== s.addr) begin
            show_mismatch("data_sram.addr", s.addr, data_sram.addr);
            mem_errs++;
        end
        for (int b = 0; b < 4; b++) begin
            if (s.we[b] && data_sram.wdata[8*b +: 8] !== s.wdata[8*b +: 8]) begin
                show_mismatch("data_sram.wdata", s.wdata, data_sram.wdata);
                mem_errs++;
            end
        end
    endtask

    task automatic check_writeback(input rf_wr_t w, input lsu_ex_t e);
        if (rf_wr.we !== w.we) begin
            show_mismatch("rf_wr.we", 32'(w.we), 32'(rf_wr.we));
            wb_errs++;
        end
        if (w.we && rf_wr.wnum !== w.wnum) begin
            show_mismatch("rf_wr.wnum", 32'(w.wnum), 32'(rf_wr.wnum));
            wb_errs++;
        end
        if (w.we && rf_wr.wdata !== w.wdata) begin
            show_mismatch("rf_wr.wdata", w.wdata, rf_wr.wdata);
            wb_errs++;
        end
        if (ex.valid !== e.valid) begin
            show_mismatch("ex.valid", 32'(e.valid), 32'(ex.valid));
            ex_errs++;
        end
        if (e.valid && ex.ecode !== e.ecode) begin
            show_mismatch("ex.ecode", 32'(e.ecode), 32'(ex.ecode));
            ex_errs++;
        end
        if (e.valid && ex.badv !== e.badv) begin
            show_mismatch("ex.badv", e.badv, ex.badv);
            ex_errs++;
        end
    endtask

    // quiet outputs while in or just out of reset
    task automatic check_idle();
        if (rf_wr.we !== 1'b0) begin
            show_mismatch("rf_wr.we", 32'h0, 32'(rf_wr.we));
            reset_errs++;
        end
        if (ex.valid !== 1'b0) begin
            show_mismatch("ex.valid", 32'h0, 32'(ex.valid));
            reset_errs++;
        end
        if (data_sram.en !== 1'b0) begin
            show_mismatch("data_sram.en", 32'h0, 32'(data_sram.en));
            reset_errs++;
        end
    endtask

    task automatic print_counts();
        $display("errors: mem_stage=%0d writeback=%0d exception=%0d reset=%0d",
                 mem_errs, wb_errs, ex_errs, reset_errs);
    endtask

    initial begin
        seed = 32'hf38e_4752;
        arst_n = 1'b0;
        req = '0;
        data_sram_rdata = '0;
        mem_errs = 0;
        wb_errs = 0;
        ex_errs = 0;
        reset_errs = 0;
        last_store = 1'b0;
        last_word = '0;
        for (int i = 0; i < 64; i++) begin
            sram_mem[i] = fill_word(i);
            shadow[i] = fill_word(i);
        end
        repeat (5) begin
            @(negedge clk);
            check_idle();
        end
        @(posedge clk);
        #1 arst_n = 1'b1;
        repeat (3) begin
            @(negedge clk);
            check_idle();
        end
        prev_rf = '0;                           // idle slot before the first request
        prev_ex = '0;
        for (int i = 0; i < n_req; i++) begin
            @(posedge clk);
            #1;
            build_request(cur_req);
            req = cur_req;
            predict(cur_req, cur_sram, cur_rf, cur_ex);
            @(negedge clk);
            check_mem_stage(cur_sram);
            check_writeback(prev_rf, prev_ex);
            update_shadow(cur_sram);
            prev_rf = cur_rf;
            prev_ex = cur_ex;
        end
        @(posedge clk);
        #1 req = '0;
        @(negedge clk);
        check_writeback(prev_rf, prev_ex);      // drain the last request
        print_counts();
        if (mem_errs + wb_errs + ex_errs + reset_errs == 0) begin
            $display("Test passed");
        end else begin
            $display("Test failed");
        end
        $finish;
    end

endmodule

/* src.f */
rtl/la_isa_pkg.sv
rtl/lsu_bus_pkg.sv
rtl/lsu_align_check.sv
rtl/lsu_store_format.sv
rtl/lsu_commit.sv
rtl/lsu_top.sv
testbench/lsu_props.sv
testbench/tb_lsu_top.sv

/* run.sh */
#!/usr/bin/env bash
# build and run the lsu testbench with verilator
set -u

cd "$(dirname "$0")" || exit 1

build_dir=obj_dir
log_file=sim.log

verilator --binary --timing --assert -j 0 \
    --timescale 1ns/1ps \
    --top-module tb_lsu_top \
    --Mdir "$build_dir" \
    -f src.f
if [ $? -ne 0 ]; then
    echo "verilator build failed"
    exit 1
fi

"./$build_dir/Vtb_lsu_top" > "$log_file" 2>&1
sim_status=$?
cat "$log_file"
if [ $sim_status -ne 0 ]; then
    echo "simulation exited with status $sim_status"
    exit 1
fi

if grep -q "^Test passed$" "$log_file"; then
    exit 0
fi
echo "pass message not found in $log_file"
exit 1
